// File: Makefile
VERILATOR ?= verilator
TOP       ?= int_core_tb
FILELIST  ?= int_core.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= SIMULATION FAILED
PASS_MSG  ?= SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed"; exit 1; \
	elif grep -q "$(PASS_MSG)" $(LOG); then echo "test passed"; \
	else echo "no result found in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: int_core.f
+incdir+source
source/int_core_pkg.sv
source/instr_decode.sv
source/alu_execute.sv
source/result_writeback.sv
source/int_core.sv
sim/int_core_tb.sv

// File: sim/int_core_tb.sv
`timescale 1ns/1ns
`include "int_core_defines.svh"

module int_core_tb;

    localparam int HOLD_CYCLES = 30;  // Output credits withheld this long after reset

    logic                      clk;
    logic                      rst_n;
    logic                      instr_valid;
    int_core_pkg::instr_t      instr;
    logic                      instr_credit;
    logic                      res_valid;
    int_core_pkg::reg_addr_t   res_dest;
    int_core_pkg::word_t       res_data;
    int_core_pkg::res_status_e res_status;
    logic                      res_credit;

    string                     tbl_name   [$];
    int_core_pkg::instr_t      tbl_instr  [$];
    int_core_pkg::reg_addr_t   tbl_dest   [$];
    int_core_pkg::word_t       tbl_data   [$];
    int_core_pkg::res_status_e tbl_status [$];
    bit                        tbl_rb     [$];  // Expect the mirrored value of rs

    int_core_pkg::word_t mirror [`INT_CORE_NREGS] = '{default: '0};

    integer seed;
    int     n_entries;
    int     sent;
    int     up_credits;
    int     rec_idx;
    int     records_seen;
    int     held_records;
    int     credit_pulses;
    int     credits_returned;
    int     hold_cycles;
    int     delay;
    bit     withhold;
    int     mon_errs;
    int     mon_fail;
    int     end_fail;

    int_core int_core_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int_core_pkg::instr_t encode_r(logic [5:0] funct, int rs, int rt,
                                                      int rd, int shamt);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), funct};
    endfunction

    function automatic int_core_pkg::instr_t encode_i(logic [5:0] op, int rs, int rt,
                                                      logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    task automatic add_entry(string name, int_core_pkg::instr_t ins, int dest,
                             int_core_pkg::word_t data, int_core_pkg::res_status_e st, bit rb);
        tbl_name.push_back(name);
        tbl_instr.push_back(ins);
        tbl_dest.push_back(int_core_pkg::reg_addr_t'(dest));
        tbl_data.push_back(data);
        tbl_status.push_back(st);
        tbl_rb.push_back(rb);
    endtask

    task automatic add_ok(string name, int_core_pkg::instr_t ins, int dest,
                          int_core_pkg::word_t data);
        add_entry(name, ins, dest, data, int_core_pkg::ST_OK, 1'b0);
    endtask

    task automatic add_readback(string name, int_core_pkg::instr_t ins, int dest);
        add_entry(name, ins, dest, '0, int_core_pkg::ST_OK, 1'b1);
    endtask

    task automatic add_overflow(string name, int_core_pkg::instr_t ins, int dest);
        add_entry(name, ins, dest, '0, int_core_pkg::ST_OVF, 1'b0);
    endtask

    task automatic add_illegal(string name, int_core_pkg::instr_t ins);
        add_entry(name, ins, 0, '0, int_core_pkg::ST_ILLEGAL, 1'b0);
    endtask

    task automatic build_table();
        // Immediate forms
        add_ok("lui", encode_i(int_core_pkg::OP_LUI, 0, 1, 16'h1234), 1, 32'h1234_0000);
        add_ok("ori", encode_i(int_core_pkg::OP_ORI, 1, 1, 16'h5678), 1, 32'h1234_5678);
        add_ok("lui", encode_i(int_core_pkg::OP_LUI, 0, 2, 16'h8000), 2, 32'h8000_0000);
        add_ok("ori", encode_i(int_core_pkg::OP_ORI, 2, 2, 16'h00ff), 2, 32'h8000_00ff);
        add_ok("addi", encode_i(int_core_pkg::OP_ADDI, 0, 3, 16'hffff), 3, 32'hffff_ffff);
        add_ok("addiu", encode_i(int_core_pkg::OP_ADDIU, 1, 4, 16'h8000), 4, 32'h1233_d678);
        add_ok("andi", encode_i(int_core_pkg::OP_ANDI, 3, 5, 16'h8001), 5, 32'h0000_8001);
        add_ok("ori", encode_i(int_core_pkg::OP_ORI, 0, 6, 16'h8000), 6, 32'h0000_8000);
        add_ok("xori", encode_i(int_core_pkg::OP_XORI, 3, 7, 16'h00ff), 7, 32'hffff_ff00);
        add_ok("slti", encode_i(int_core_pkg::OP_SLTI, 3, 8, 16'h0001), 8, 32'h1);
        add_ok("sltiu", encode_i(int_core_pkg::OP_SLTIU, 3, 9, 16'h0001), 9, 32'h0);
        add_ok("sltiu", encode_i(int_core_pkg::OP_SLTIU, 0, 10, 16'hffff), 10, 32'h1);
        // Register forms, some back to back on the same register
        add_ok("add", encode_r(int_core_pkg::FN_ADD, 1, 2, 11, 0), 11, 32'h9234_5777);
        add_ok("addu", encode_r(int_core_pkg::FN_ADDU, 11, 3, 12, 0), 12, 32'h9234_5776);
        add_ok("sub", encode_r(int_core_pkg::FN_SUB, 1, 6, 13, 0), 13, 32'h1233_d678);
        add_ok("subu", encode_r(int_core_pkg::FN_SUBU, 0, 1, 14, 0), 14, 32'hedcb_a988);
        add_ok("and", encode_r(int_core_pkg::FN_AND, 1, 2, 15, 0), 15, 32'h0000_0078);
        add_ok("or", encode_r(int_core_pkg::FN_OR, 1, 2, 16, 0), 16, 32'h9234_56ff);
        add_ok("xor", encode_r(int_core_pkg::FN_XOR, 1, 2, 17, 0), 17, 32'h9234_5687);
        add_ok("nor", encode_r(int_core_pkg::FN_NOR, 1, 2, 18, 0), 18, 32'h6dcb_a900);
        add_ok("slt", encode_r(int_core_pkg::FN_SLT, 2, 1, 19, 0), 19, 32'h1);
        add_ok("sltu", encode_r(int_core_pkg::FN_SLTU, 2, 1, 20, 0), 20, 32'h0);
        add_ok("or", encode_r(int_core_pkg::FN_OR, 20, 19, 21, 0), 21, 32'h1);
        // Shifts
        add_ok("sll", encode_r(int_core_pkg::FN_SLL, 0, 1, 22, 4), 22, 32'h2345_6780);
        add_ok("srl", encode_r(int_core_pkg::FN_SRL, 0, 2, 23, 8), 23, 32'h0080_0000);
        add_ok("sra", encode_r(int_core_pkg::FN_SRA, 0, 2, 24, 8), 24, 32'hff80_0000);
        add_ok("addiu", encode_i(int_core_pkg::OP_ADDIU, 0, 25, 16'd36), 25, 32'h24);
        add_ok("sllv", encode_r(int_core_pkg::FN_SLLV, 25, 1, 26, 0), 26, 32'h2345_6780);
        add_ok("srlv", encode_r(int_core_pkg::FN_SRLV, 25, 2, 27, 0), 27, 32'h0800_000f);
        add_ok("srav", encode_r(int_core_pkg::FN_SRAV, 25, 2, 28, 0), 28, 32'hf800_000f);
        // Overflow keeps the old destination value
        add_ok("lui", encode_i(int_core_pkg::OP_LUI, 0, 29, 16'h7fff), 29, 32'h7fff_0000);
        add_overflow("add", encode_r(int_core_pkg::FN_ADD, 29, 29, 5, 0), 5);
        add_readback("or", encode_r(int_core_pkg::FN_OR, 5, 0, 9, 0), 9);
        add_ok("addu", encode_r(int_core_pkg::FN_ADDU, 29, 29, 5, 0), 5, 32'hfffe_0000);
        add_readback("or", encode_r(int_core_pkg::FN_OR, 5, 0, 10, 0), 10);
        add_overflow("sub", encode_r(int_core_pkg::FN_SUB, 2, 1, 6, 0), 6);
        add_readback("or", encode_r(int_core_pkg::FN_OR, 6, 0, 11, 0), 11);
        add_ok("ori", encode_i(int_core_pkg::OP_ORI, 29, 29, 16'hffff), 29, 32'h7fff_ffff);
        add_overflow("addi", encode_i(int_core_pkg::OP_ADDI, 29, 7, 16'h0001), 7);
        add_readback("or", encode_r(int_core_pkg::FN_OR, 7, 0, 12, 0), 12);
        // NOP, r0 and dropped opcodes
        add_ok("nop", 32'h0000_0000, 0, 32'h0);
        add_ok("addiu", encode_i(int_core_pkg::OP_ADDIU, 1, 0, 16'h0001), 0, 32'h1234_5679);
        add_readback("or", encode_r(int_core_pkg::FN_OR, 0, 0, 13, 0), 13);
        add_illegal("lw", encode_i(6'h23, 2, 1, 16'h0000));
        add_readback("or", encode_r(int_core_pkg::FN_OR, 1, 0, 14, 0), 14);
        add_illegal("mult", encode_r(6'h18, 1, 2, 0, 0));
        add_illegal("beq", encode_i(6'h04, 1, 2, 16'h0010));
        add_ok("sltu", encode_r(int_core_pkg::FN_SLTU, 0, 1, 15, 0), 15, 32'h1);
    endtask

    task automatic check_data(string sig, int_core_pkg::word_t got, int_core_pkg::word_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, sig, got, exp);
            mon_errs++;
        end
    endtask

    task automatic check_dest(string sig, int_core_pkg::reg_addr_t got,
                              int_core_pkg::reg_addr_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is r%0d, expected r%0d", $time, sig, got, exp);
            mon_errs++;
        end
    endtask

    task automatic check_status(string sig, int_core_pkg::res_status_e got,
                                int_core_pkg::res_status_e exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %s, expected %s", $time, sig, got.name(),
                     exp.name());
            mon_errs++;
        end
    endtask

    // Downstream credit model
    initial begin
        seed             = 18336;
        res_credit       = 1'b0;
        withhold         = 1'b1;
        credits_returned = 0;
        hold_cycles      = 0;
        delay            = 0;
        forever begin
            @(posedge clk);
            if (rst_n && hold_cycles < HOLD_CYCLES)
                hold_cycles++;
            withhold = (hold_cycles < HOLD_CYCLES);
            if (rst_n && !withhold && records_seen > credits_returned && delay == 0) begin
                res_credit <= 1'b1;
                credits_returned++;
                delay = $random(seed) & 3;
            end else begin
                res_credit <= 1'b0;
                if (delay > 0)
                    delay--;
            end
        end
    end

    // Outputs sampled mid cycle
    always @(negedge clk) begin
        int_core_pkg::word_t exp_data;
        int errs_before;
        if (rst_n) begin
            if (instr_credit)
                credit_pulses++;
            if (res_valid) begin
                records_seen++;
                if (withhold)
                    held_records++;
                if (rec_idx >= n_entries) begin
                    $display("Record at %0t ns arrived after the last table entry", $time);
                    mon_errs++;
                end else begin
                    errs_before = mon_errs;
                    exp_data = tbl_rb[rec_idx] ? mirror[tbl_instr[rec_idx][25:21]]
                                               : tbl_data[rec_idx];
                    if (tbl_status[rec_idx] != int_core_pkg::ST_ILLEGAL)
                        check_dest("res_dest", res_dest, tbl_dest[rec_idx]);
                    if (tbl_status[rec_idx] == int_core_pkg::ST_OK)
                        check_data("res_data", res_data, exp_data);
                    check_status("res_status", res_status, tbl_status[rec_idx]);
                    if (tbl_status[rec_idx] == int_core_pkg::ST_OK && tbl_dest[rec_idx] != '0)
                        mirror[tbl_dest[rec_idx]] = exp_data;
                    if (mon_errs != errs_before)
                        mon_fail++;
                    $display("test %0d %s: %s", rec_idx, tbl_name[rec_idx],
                             (mon_errs == errs_before) ? "ok" : "mismatch");
                    rec_idx++;
                end
            end
        end
    end

    initial begin
        wait (n_entries > 0);
        repeat (n_entries * 50) @(posedge clk);
        $display("Timeout, %0d of %0d records received", rec_idx, n_entries);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        sent        = 0;
        end_fail    = 0;
        build_table();
        n_entries = tbl_instr.size();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        up_credits = `INT_CORE_IN_DEPTH;
        while (sent < n_entries) begin
            @(posedge clk);
            if (instr_credit)
                up_credits++;
            if (up_credits > 0) begin
                instr_valid <= 1'b1;
                instr       <= tbl_instr[sent];
                sent++;
                up_credits--;
            end else begin
                instr_valid <= 1'b0;
            end
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        while (rec_idx < n_entries)
            @(posedge clk);
        repeat (4) @(posedge clk);
        if (held_records > `INT_CORE_RES_DEPTH) begin
            $display("Back-pressure broken, %0d records came out with credits withheld",
                     held_records);
            end_fail++;
        end else begin
            $display("test back-pressure: ok, %0d records while withheld", held_records);
        end
        if (credit_pulses != sent) begin
            $display("Credit count wrong, %0d instr_credit pulses for %0d instructions",
                     credit_pulses, sent);
            end_fail++;
        end else begin
            $display("test instr_credit count: ok, %0d pulses", credit_pulses);
        end
        $display("Summary: %0d tests, %0d failed, %0d value errors", n_entries + 2,
                 mon_fail + end_fail, mon_errs);
        if (mon_errs == 0 && mon_fail == 0 && end_fail == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: source/alu_execute.sv
`timescale 1ns/1ns
`include "int_core_defines.svh"

module alu_execute (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      ex_valid,
    input  int_core_pkg::alu_op_e     ex_alu_op,
    input  int_core_pkg::shift_op_e   ex_shift_op,
    input  logic                      ex_is_shift,
    input  logic                      ex_shamt_var,
    input  logic                      ex_use_imm,
    input  int_core_pkg::word_t       ex_imm,
    input  logic [4:0]                ex_shamt,
    input  logic                      ex_of_check,
    input  int_core_pkg::reg_addr_t   ex_dest,
    input  logic                      ex_write,
    input  int_core_pkg::res_status_e ex_status,
    input  int_core_pkg::word_t       ex_rs_data,
    input  int_core_pkg::word_t       ex_rt_data,
    output logic                      wb_valid,
    output int_core_pkg::reg_addr_t   wb_dest,
    output int_core_pkg::word_t       wb_data,
    output logic                      wb_write,
    output int_core_pkg::res_status_e wb_status
);

    localparam int MSB = `INT_CORE_XLEN - 1;

    int_core_pkg::word_t op_b;
    int_core_pkg::word_t alu_res;
    int_core_pkg::word_t sh_res;
    logic [4:0]          sh_amt;
    logic                ovf;

    assign op_b   = ex_use_imm ? ex_imm : ex_rt_data;
    assign sh_amt = ex_shamt_var ? ex_rs_data[4:0] : ex_shamt;

    always_comb begin
        case (ex_alu_op)
            int_core_pkg::ALU_ADD, int_core_pkg::ALU_ADDU: alu_res = ex_rs_data + op_b;
            int_core_pkg::ALU_SUB, int_core_pkg::ALU_SUBU: alu_res = ex_rs_data - op_b;
            int_core_pkg::ALU_AND:  alu_res = ex_rs_data & op_b;
            int_core_pkg::ALU_OR:   alu_res = ex_rs_data | op_b;
            int_core_pkg::ALU_XOR:  alu_res = ex_rs_data ^ op_b;
            int_core_pkg::ALU_NOR:  alu_res = ~(ex_rs_data | op_b);
            int_core_pkg::ALU_SLT:
                alu_res = int_core_pkg::word_t'($signed(ex_rs_data) < $signed(op_b));
            int_core_pkg::ALU_SLTU: alu_res = int_core_pkg::word_t'(ex_rs_data < op_b);
            default:                alu_res = '0;
        endcase
    end

    // Shifts operate on rt
    always_comb begin
        case (ex_shift_op)
            int_core_pkg::SH_RL: sh_res = ex_rt_data >> sh_amt;
            int_core_pkg::SH_RA: sh_res = $signed(ex_rt_data) >>> sh_amt;
            default:             sh_res = ex_rt_data << sh_amt;
        endcase
    end

    // Result sign flips away from like-signed operands
    always_comb begin
        if (ex_alu_op == int_core_pkg::ALU_SUB)  // b counts negated
            ovf = (ex_rs_data[MSB] != op_b[MSB]) && (alu_res[MSB] != ex_rs_data[MSB]);
        else
            ovf = (ex_rs_data[MSB] == op_b[MSB]) && (alu_res[MSB] != ex_rs_data[MSB]);
        ovf = ovf && ex_of_check;
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            wb_valid <= 1'b0;
        else
            wb_valid <= ex_valid;
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            wb_dest   <= ex_dest;
            wb_data   <= ex_is_shift ? sh_res : alu_res;
            wb_write  <= ex_write && !ovf;  // Overflow drops the write
            wb_status <= ovf ? int_core_pkg::ST_OVF : ex_status;
        end
    end

    // Overflow rule above only fits the signed add and subtract
    a_of_check_op: assert property (@(posedge clk) disable iff (!rst_n)
        ex_valid && ex_of_check |->
            ex_alu_op inside {int_core_pkg::ALU_ADD, int_core_pkg::ALU_SUB});

endmodule

// File: source/instr_decode.sv
`timescale 1ns/1ns
`include "int_core_defines.svh"

module instr_decode (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      instr_valid,
    input  int_core_pkg::instr_t      instr,
    input  logic                      issue_credit,
    input  logic                      wr_en,
    input  int_core_pkg::reg_addr_t   wr_addr,
    input  int_core_pkg::word_t       rd_data_a,
    input  int_core_pkg::word_t       rd_data_b,
    output logic                      instr_credit,
    output int_core_pkg::reg_addr_t   rd_addr_a,
    output int_core_pkg::reg_addr_t   rd_addr_b,
    output logic                      ex_valid,
    output int_core_pkg::alu_op_e     ex_alu_op,
    output int_core_pkg::shift_op_e   ex_shift_op,
    output logic                      ex_is_shift,
    output logic                      ex_shamt_var,
    output logic                      ex_use_imm,
    output int_core_pkg::word_t       ex_imm,
    output logic [4:0]                ex_shamt,
    output logic                      ex_of_check,
    output int_core_pkg::reg_addr_t   ex_dest,
    output logic                      ex_write,
    output int_core_pkg::res_status_e ex_status,
    output int_core_pkg::word_t       ex_rs_data,
    output int_core_pkg::word_t       ex_rt_data
);

    localparam int IN_AW = $clog2(`INT_CORE_IN_DEPTH);
    localparam int CW    = $clog2(`INT_CORE_RES_DEPTH + 1);

    int_core_pkg::instr_t        buf_mem [`INT_CORE_IN_DEPTH];
    logic [IN_AW-1:0]            wr_ptr;  // Power of two depth, pointers wrap
    logic [IN_AW-1:0]            rd_ptr;
    logic [IN_AW:0]              buf_count;
    logic [CW-1:0]               credits;
    logic [`INT_CORE_NREGS-1:0]  pending;
    int_core_pkg::instr_t        head;
    int_core_pkg::alu_op_e       alu_op;
    int_core_pkg::shift_op_e     shift_op;
    int_core_pkg::imm_ext_e      imm_ext;
    int_core_pkg::res_status_e   status;
    int_core_pkg::reg_addr_t     dest;
    int_core_pkg::word_t         imm;
    logic is_shift, use_imm, of_check, write, illegal, hazard, issue;

    assign head      = buf_mem[rd_ptr];
    assign rd_addr_a = head[25:21];
    assign rd_addr_b = head[20:16];

    always_comb begin
        alu_op   = int_core_pkg::ALU_ADDU;
        shift_op = int_core_pkg::SH_LL;
        is_shift = 1'b0;
        use_imm  = 1'b1;
        of_check = 1'b0;
        imm_ext  = int_core_pkg::EXT_SIGN;
        dest     = head[20:16];  // Immediate forms write rt
        illegal  = 1'b0;
        case (head[31:26])
            int_core_pkg::OP_SPECIAL: begin
                use_imm  = 1'b0;
                dest     = head[15:11];
                is_shift = (head[5:3] == 3'b000);
                case (head[5:0])
                    int_core_pkg::FN_ADD: begin
                        alu_op   = int_core_pkg::ALU_ADD;
                        of_check = 1'b1;
                    end
                    int_core_pkg::FN_SUB: begin
                        alu_op   = int_core_pkg::ALU_SUB;
                        of_check = 1'b1;
                    end
                    int_core_pkg::FN_ADDU: alu_op = int_core_pkg::ALU_ADDU;
                    int_core_pkg::FN_SUBU: alu_op = int_core_pkg::ALU_SUBU;
                    int_core_pkg::FN_AND:  alu_op = int_core_pkg::ALU_AND;
                    int_core_pkg::FN_OR:   alu_op = int_core_pkg::ALU_OR;
                    int_core_pkg::FN_XOR:  alu_op = int_core_pkg::ALU_XOR;
                    int_core_pkg::FN_NOR:  alu_op = int_core_pkg::ALU_NOR;
                    int_core_pkg::FN_SLT:  alu_op = int_core_pkg::ALU_SLT;
                    int_core_pkg::FN_SLTU: alu_op = int_core_pkg::ALU_SLTU;
                    int_core_pkg::FN_SLL, int_core_pkg::FN_SLLV: shift_op = int_core_pkg::SH_LL;
                    int_core_pkg::FN_SRL, int_core_pkg::FN_SRLV: shift_op = int_core_pkg::SH_RL;
                    int_core_pkg::FN_SRA, int_core_pkg::FN_SRAV: shift_op = int_core_pkg::SH_RA;
                    default: illegal = 1'b1;
                endcase
            end
            int_core_pkg::OP_ADDI: begin
                alu_op   = int_core_pkg::ALU_ADD;
                of_check = 1'b1;
            end
            int_core_pkg::OP_ADDIU: alu_op = int_core_pkg::ALU_ADDU;
            int_core_pkg::OP_SLTI:  alu_op = int_core_pkg::ALU_SLT;
            int_core_pkg::OP_SLTIU: alu_op = int_core_pkg::ALU_SLTU;
            int_core_pkg::OP_ANDI: begin
                alu_op  = int_core_pkg::ALU_AND;
                imm_ext = int_core_pkg::EXT_ZERO;
            end
            int_core_pkg::OP_ORI: begin
                alu_op  = int_core_pkg::ALU_OR;
                imm_ext = int_core_pkg::EXT_ZERO;
            end
            int_core_pkg::OP_XORI: begin
                alu_op  = int_core_pkg::ALU_XOR;
                imm_ext = int_core_pkg::EXT_ZERO;
            end
            int_core_pkg::OP_LUI: imm_ext = int_core_pkg::EXT_UPPER;  // rs is r0
            default: illegal = 1'b1;
        endcase
        // All-zero NOP decodes as SLL into r0
        write  = !illegal;
        status = illegal ? int_core_pkg::ST_ILLEGAL : int_core_pkg::ST_OK;
        if (illegal)
            dest = '0;
        case (imm_ext)
            int_core_pkg::EXT_SIGN:  imm = {{16{head[15]}}, head[15:0]};
            int_core_pkg::EXT_UPPER: imm = {head[15:0], 16'h0000};
            default:                 imm = {16'h0000, head[15:0]};
        endcase
    end

    // Conservative, rs and rt both checked even when unused
    assign hazard = pending[rd_addr_a] | pending[rd_addr_b] | pending[dest];
    assign issue  = (buf_count != '0) && (credits != '0) && !hazard;

    always_ff @(posedge clk) begin
        if (instr_valid)
            buf_mem[wr_ptr] <= instr;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            buf_count    <= '0;
            credits      <= CW'(`INT_CORE_RES_DEPTH);
            pending      <= '0;
            instr_credit <= 1'b0;
            ex_valid     <= 1'b0;
        end else begin
            if (instr_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (issue)
                rd_ptr <= rd_ptr + 1'b1;
            case ({instr_valid, issue})
                2'b10:   buf_count <= buf_count + 1'b1;
                2'b01:   buf_count <= buf_count - 1'b1;
                default: buf_count <= buf_count;
            endcase
            case ({issue, issue_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
            if (wr_en)
                pending[wr_addr] <= 1'b0;
            if (issue && write && dest != '0)
                pending[dest] <= 1'b1;
            instr_credit <= issue;  // Slot freed
            ex_valid     <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            ex_alu_op    <= alu_op;
            ex_shift_op  <= shift_op;
            ex_is_shift  <= is_shift;
            ex_shamt_var <= is_shift && head[2];  // SLLV, SRLV, SRAV
            ex_use_imm   <= use_imm;
            ex_imm       <= imm;
            ex_shamt     <= head[10:6];
            ex_of_check  <= of_check;
            ex_dest      <= dest;
            ex_write     <= write;
            ex_status    <= status;
            ex_rs_data   <= rd_data_a;
            ex_rt_data   <= rd_data_b;
        end
    end

    a_no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        !(instr_valid && buf_count == `INT_CORE_IN_DEPTH));

    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= `INT_CORE_RES_DEPTH);

endmodule

// File: source/int_core.sv
`timescale 1ns/1ns

module int_core (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      instr_valid,
    input  int_core_pkg::instr_t      instr,
    output logic                      instr_credit,
    output logic                      res_valid,
    output int_core_pkg::reg_addr_t   res_dest,
    output int_core_pkg::word_t       res_data,
    output int_core_pkg::res_status_e res_status,
    input  logic                      res_credit
);

    // Decode to execute
    logic                      ex_valid;
    int_core_pkg::alu_op_e     ex_alu_op;
    int_core_pkg::shift_op_e   ex_shift_op;
    logic                      ex_is_shift;
    logic                      ex_shamt_var;
    logic                      ex_use_imm;
    int_core_pkg::word_t       ex_imm;
    logic [4:0]                ex_shamt;
    logic                      ex_of_check;
    int_core_pkg::reg_addr_t   ex_dest;
    logic                      ex_write;
    int_core_pkg::res_status_e ex_status;
    int_core_pkg::word_t       ex_rs_data;
    int_core_pkg::word_t       ex_rt_data;

    // Execute to result
    logic                      wb_valid;
    int_core_pkg::reg_addr_t   wb_dest;
    int_core_pkg::word_t       wb_data;
    logic                      wb_write;
    int_core_pkg::res_status_e wb_status;

    // Register file ports, scoreboard release and issue credits
    int_core_pkg::reg_addr_t   rd_addr_a;
    int_core_pkg::reg_addr_t   rd_addr_b;
    int_core_pkg::word_t       rd_data_a;
    int_core_pkg::word_t       rd_data_b;
    logic                      wr_en;
    int_core_pkg::reg_addr_t   wr_addr;
    logic                      issue_credit;

    instr_decode instr_decode_inst (.*);

    alu_execute alu_execute_inst (.*);

    result_writeback result_writeback_inst (.*);

endmodule

// File: source/int_core_defines.svh
`ifndef INT_CORE_DEFINES_SVH
`define INT_CORE_DEFINES_SVH

// Data word width
`define INT_CORE_XLEN 32

// Architectural registers, r0 reads zero
`define INT_CORE_NREGS 32

`define INT_CORE_IN_DEPTH 4   // Instruction buffer, also upstream credits at reset
`define INT_CORE_RES_DEPTH 4  // Result buffer, also output and issue credits

`endif

// File: source/int_core_pkg.sv
`include "int_core_defines.svh"

package int_core_pkg;

    typedef logic [`INT_CORE_XLEN-1:0] word_t;
    typedef logic [$clog2(`INT_CORE_NREGS)-1:0] reg_addr_t;
    typedef logic [31:0] instr_t;

    // Major opcodes in instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDI    = 6'h08,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_e;

    // SPECIAL function codes in instr[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_SLLV = 6'h04,
        FN_SRLV = 6'h06,
        FN_SRAV = 6'h07,
        FN_ADD  = 6'h20,
        FN_ADDU = 6'h21,
        FN_SUB  = 6'h22,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADDU = 4'b0000,
        ALU_SUBU = 4'b0001,
        ALU_AND  = 4'b0100,
        ALU_SLT  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_SLTU = 4'b0111,
        ALU_NOR  = 4'b1000,
        ALU_XOR  = 4'b1001,
        ALU_ADD  = 4'b1110,  // Signed, overflow checked
        ALU_SUB  = 4'b1111
    } alu_op_e;

    typedef enum logic [1:0] {
        SH_LL = 2'b00,
        SH_RL = 2'b01,
        SH_RA = 2'b10
    } shift_op_e;

    typedef enum logic [1:0] {
        EXT_ZERO  = 2'b00,
        EXT_SIGN  = 2'b01,
        EXT_UPPER = 2'b10
    } imm_ext_e;

    typedef enum logic [1:0] {
        ST_OK      = 2'b00,
        ST_OVF     = 2'b01,
        ST_ILLEGAL = 2'b10
    } res_status_e;

endpackage

// File: source/result_writeback.sv
`timescale 1ns/1ns
`include "int_core_defines.svh"

module result_writeback (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      wb_valid,
    input  int_core_pkg::reg_addr_t   wb_dest,
    input  int_core_pkg::word_t       wb_data,
    input  logic                      wb_write,
    input  int_core_pkg::res_status_e wb_status,
    input  int_core_pkg::reg_addr_t   rd_addr_a,
    input  int_core_pkg::reg_addr_t   rd_addr_b,
    input  logic                      res_credit,
    output int_core_pkg::word_t       rd_data_a,
    output int_core_pkg::word_t       rd_data_b,
    output logic                      wr_en,
    output int_core_pkg::reg_addr_t   wr_addr,
    output logic                      res_valid,
    output int_core_pkg::reg_addr_t   res_dest,
    output int_core_pkg::word_t       res_data,
    output int_core_pkg::res_status_e res_status,
    output logic                      issue_credit
);

    localparam int RES_AW = $clog2(`INT_CORE_RES_DEPTH);
    localparam int CW     = $clog2(`INT_CORE_RES_DEPTH + 1);

    int_core_pkg::word_t       regs     [`INT_CORE_NREGS];
    int_core_pkg::reg_addr_t   q_dest   [`INT_CORE_RES_DEPTH];
    int_core_pkg::word_t       q_data   [`INT_CORE_RES_DEPTH];
    int_core_pkg::res_status_e q_status [`INT_CORE_RES_DEPTH];
    logic [RES_AW-1:0]         q_wr;
    logic [RES_AW-1:0]         q_rd;
    logic [RES_AW:0]           q_count;
    logic [CW-1:0]             out_credits;
    logic                      pop;

    // r0 is never written and always reads zero
    always_ff @(posedge clk) begin
        if (wb_valid && wb_write && wb_dest != '0)
            regs[wb_dest] <= wb_data;
    end

    assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
    assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

    // Retires the destination even when overflow dropped the write
    assign wr_en   = wb_valid && wb_dest != '0;
    assign wr_addr = wb_dest;

    always_ff @(posedge clk) begin
        if (wb_valid) begin
            q_dest[q_wr]   <= wb_dest;
            q_data[q_wr]   <= wb_data;
            q_status[q_wr] <= wb_status;
        end
    end

    assign pop          = (q_count != '0) && (out_credits != '0);
    assign res_valid    = pop;
    assign res_dest     = q_dest[q_rd];
    assign res_data     = q_data[q_rd];
    assign res_status   = q_status[q_rd];
    assign issue_credit = pop;  // Entry freed for decode

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q_wr        <= '0;
            q_rd        <= '0;
            q_count     <= '0;
            out_credits <= CW'(`INT_CORE_RES_DEPTH);
        end else begin
            if (wb_valid)
                q_wr <= q_wr + 1'b1;
            if (pop)
                q_rd <= q_rd + 1'b1;
            case ({wb_valid, pop})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: q_count <= q_count;
            endcase
            case ({pop, res_credit})
                2'b10:   out_credits <= out_credits - 1'b1;
                2'b01:   out_credits <= out_credits + 1'b1;
                default: out_credits <= out_credits;
            endcase
        end
    end

    // Decode reserves an entry per issue, so a full buffer has nothing in flight
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> q_count < `INT_CORE_RES_DEPTH);

    a_out_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        out_credits <= `INT_CORE_RES_DEPTH);

endmodule
